// File: logic/modexp_cfg.svh
// ############################
// Widths are fixed here for the whole design
// The exponent must stay narrower than the modulus
// ############################

`ifndef MODEXP_CFG_SVH
`define MODEXP_CFG_SVH

// Modulus, message and result width
`define MODEXP_MOD_WIDTH 16

// Exponent width, one bit consumed per run cycle
`define MODEXP_EXP_WIDTH 4

// Completion counter, wraps on overflow
`define MODEXP_COUNT_WIDTH 8

`endif

// File: logic/modexp_pkg.sv
// ############################
// Opcode and engine state types
// ############################

`default_nettype none

package modexp_pkg;

    // Host command opcodes, unlisted codes act as NOP
    typedef enum logic [2:0] {
        CMD_NOP      = 3'd0,
        CMD_LOAD_MOD = 3'd1,
        CMD_LOAD_EXP = 3'd2,
        CMD_LOAD_MSG = 3'd3,
        CMD_START    = 3'd4
    } cmd_op_e;

    // Exponentiation engine states
    typedef enum logic [1:0] {
        ENG_IDLE = 2'd0,
        ENG_RUN  = 2'd1,
        ENG_DONE = 2'd2
    } eng_state_e;

endpackage

`default_nettype wire

// File: logic/modexp_cmd_decode.sv
// ############################
// Loads always accepted, even while busy
// Start needs idle engine and modulus >= 2
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "modexp_cfg.svh"

module modexp_cmd_decode (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cmd_valid,
    input  wire modexp_pkg::cmd_op_e     cmd_op,
    input  wire [`MODEXP_MOD_WIDTH-1:0]  cmd_data,
    input  wire                          busy,
    output logic                         start_pulse,
    output logic                         reject,
    output logic [`MODEXP_MOD_WIDTH-1:0] mod_val,
    output logic [`MODEXP_EXP_WIDTH-1:0] exp_val,
    output logic [`MODEXP_MOD_WIDTH-1:0] msg_val
);

    import modexp_pkg::*;

    logic is_start;
    logic mod_ok;
    logic start_ok;

    assign is_start = cmd_valid && (cmd_op == CMD_START);

    // Modulus >= 2 means some bit above bit 0 is set
    assign mod_ok = |mod_val[`MODEXP_MOD_WIDTH-1:1];

    // A start_pulse in flight counts as busy, the engine
    // only raises busy one cycle after it
    assign start_ok = mod_ok && !busy && !start_pulse;

    // Operand registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mod_val <= '0;
            exp_val <= '0;
            msg_val <= '0;
        end else if (cmd_valid) begin
            case (cmd_op)
                CMD_LOAD_MOD: begin
                    mod_val <= cmd_data;
                end
                CMD_LOAD_EXP: begin
                    // Only the low exponent bits are meaningful
                    exp_val <= cmd_data[`MODEXP_EXP_WIDTH-1:0];
                end
                CMD_LOAD_MSG: begin
                    msg_val <= cmd_data;
                end
                default: begin
                end
            endcase
        end
    end

    // Start decision, exactly one of the two pulses per start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_pulse <= 1'b0;
            reject      <= 1'b0;
        end else begin
            start_pulse <= is_start && start_ok;
            reject      <= is_start && !start_ok;
        end
    end

endmodule

`default_nettype wire

// File: logic/modexp_engine.sv
// ############################
// Right-to-left square and multiply
// Caller guarantees modulus >= 2 on start
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "modexp_cfg.svh"

module modexp_engine (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start_pulse,
    input  wire [`MODEXP_MOD_WIDTH-1:0]  mod_val,
    input  wire [`MODEXP_EXP_WIDTH-1:0]  exp_val,
    input  wire [`MODEXP_MOD_WIDTH-1:0]  msg_val,
    output logic                         busy,
    output logic                         finish_pulse,
    output logic [`MODEXP_MOD_WIDTH-1:0] final_val
);

    import modexp_pkg::*;

    localparam int MW = `MODEXP_MOD_WIDTH;
    localparam int EW = `MODEXP_EXP_WIDTH;

    eng_state_e state;

    // Working copies, loads during a run do not disturb these
    logic [MW-1:0]   mod_q;
    logic [MW-1:0]   base_q;
    logic [MW-1:0]   acc_q;
    logic [EW-1:0]   exp_q;

    // Full width products before reduction
    logic [2*MW-1:0] mul_prod;
    logic [2*MW-1:0] sqr_prod;
    logic [MW-1:0]   mul_red;
    logic [MW-1:0]   sqr_red;

    logic            last_bit;

    assign mul_prod = acc_q * base_q;
    assign sqr_prod = base_q * base_q;
    assign mul_red  = MW'(mul_prod % {{MW{1'b0}}, mod_q});
    assign sqr_red  = MW'(sqr_prod % {{MW{1'b0}}, mod_q});

    // No set bits remain above the one being processed
    assign last_bit = (exp_q[EW-1:1] == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENG_IDLE;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (start_pulse) begin
                        // Zero exponent skips straight to done
                        state <= (exp_val == '0) ? ENG_DONE : ENG_RUN;
                    end
                end
                ENG_RUN: begin
                    if (last_bit) begin
                        state <= ENG_DONE;
                    end
                end
                ENG_DONE: begin
                    state <= ENG_IDLE;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Datapath, one exponent bit per run cycle
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && start_pulse) begin
            mod_q  <= mod_val;
            base_q <= msg_val;
            exp_q  <= exp_val;
            acc_q  <= {{(MW-1){1'b0}}, 1'b1};
        end else if (state == ENG_RUN) begin
            if (exp_q[0]) begin
                acc_q <= mul_red;
            end
            base_q <= sqr_red;
            exp_q  <= exp_q >> 1;
        end
    end

    // Busy covers run cycles and the finishing cycle
    assign busy         = (state != ENG_IDLE);
    assign finish_pulse = (state == ENG_DONE);
    assign final_val    = acc_q;

endmodule

`default_nettype wire

// File: logic/modexp_result.sv
// ############################
// Result holds until next completion
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "modexp_cfg.svh"

module modexp_result (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            finish_pulse,
    input  wire [`MODEXP_MOD_WIDTH-1:0]    final_val,
    output logic [`MODEXP_MOD_WIDTH-1:0]   result,
    output logic                           done,
    output logic [`MODEXP_COUNT_WIDTH-1:0] op_count
);

    // Output register and done strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= finish_pulse;
            if (finish_pulse) begin
                result <= final_val;
            end
        end
    end

    // Completion counter, wraps silently
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_count <= '0;
        end else if (finish_pulse) begin
            op_count <= op_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/modexp_top.sv
// ############################
// Commands are strobes, no ready
// Refused starts show up on reject
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "modexp_cfg.svh"

module modexp_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            cmd_valid,
    input  wire modexp_pkg::cmd_op_e       cmd_op,
    input  wire [`MODEXP_MOD_WIDTH-1:0]    cmd_data,
    output wire [`MODEXP_MOD_WIDTH-1:0]    result,
    output wire                            done,
    output wire                            busy,
    output wire                            reject,
    output wire [`MODEXP_COUNT_WIDTH-1:0]  op_count
);

    // Decode to engine
    wire                          start_pulse;
    wire [`MODEXP_MOD_WIDTH-1:0]  mod_val;
    wire [`MODEXP_EXP_WIDTH-1:0]  exp_val;
    wire [`MODEXP_MOD_WIDTH-1:0]  msg_val;

    // Engine to result
    wire                          finish_pulse;
    wire [`MODEXP_MOD_WIDTH-1:0]  final_val;

    modexp_cmd_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_data    (cmd_data),
        .busy        (busy),
        .start_pulse (start_pulse),
        .reject      (reject),
        .mod_val     (mod_val),
        .exp_val     (exp_val),
        .msg_val     (msg_val)
    );

    modexp_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .start_pulse  (start_pulse),
        .mod_val      (mod_val),
        .exp_val      (exp_val),
        .msg_val      (msg_val),
        .busy         (busy),
        .finish_pulse (finish_pulse),
        .final_val    (final_val)
    );

    modexp_result u_result (
        .clk          (clk),
        .rst          (rst),
        .finish_pulse (finish_pulse),
        .final_val    (final_val),
        .result       (result),
        .done         (done),
        .op_count     (op_count)
    );

endmodule

`default_nettype wire

// File: testbench/modexp_properties.sv
// ##############################
// Handshake checks, bound into modexp_top
// ##############################

`timescale 1ns/100ps
`default_nettype none

module modexp_properties (
    input wire clk,
    input wire rst,
    input wire done,
    input wire reject,
    input wire busy,
    input wire start_pulse,
    input wire finish_pulse
);

    // Number of failed assertions so far
    int fail_count = 0;

    // A start is either completed or refused, never both at once
    a_done_reject_excl: assert property (
        @(posedge clk) disable iff (rst) !(done && reject)
    ) else begin
        fail_count++;
        $error("done and reject high in the same cycle");
    end

    a_start_not_busy: assert property (
        @(posedge clk) disable iff (rst) !(start_pulse && busy)
    ) else begin
        fail_count++;
        $error("start_pulse issued while the engine is busy");
    end

    // Busy only drops after the finishing cycle
    a_busy_fall: assert property (
        @(posedge clk) disable iff (rst) $fell(busy) |-> $past(finish_pulse)
    ) else begin
        fail_count++;
        $error("busy fell without a finish_pulse");
    end

endmodule

bind modexp_top modexp_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .done         (done),
    .reject       (reject),
    .busy         (busy),
    .start_pulse  (start_pulse),
    .finish_pulse (finish_pulse)
);

`default_nettype wire

// File: testbench/modexp_tb.sv
// ##############################
// Self-checking testbench, expects modulus >= 2 on accepted starts
// Latency measured from the start strobe edge to done
// ##############################

`timescale 1ns/100ps
`default_nettype none

`include "modexp_cfg.svh"

module modexp_tb;

    import modexp_pkg::*;

    localparam int MW = `MODEXP_MOD_WIDTH;
    localparam int EW = `MODEXP_EXP_WIDTH;
    localparam int CW = `MODEXP_COUNT_WIDTH;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int MAX_LAT = EW + 3;
    localparam int NUM_OPS = 230;
    localparam int OP_CYCLES = MAX_LAT + 6;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_OPS * OP_CYCLES + 400;

    logic          clk;
    logic          rst;
    logic          cmd_valid;
    cmd_op_e       cmd_op;
    logic [MW-1:0] cmd_data;
    wire  [MW-1:0] result;
    wire           done;
    wire           busy;
    wire           reject;
    wire  [CW-1:0] op_count;

    // Outstanding responses, oldest first
    logic [MW-1:0] done_val_q[$];
    time           done_t0_q[$];
    int            done_lat_q[$];
    time           rej_t0_q[$];

    int            n_checks = 0;
    int            n_errors = 0;
    int            n_done = 0;
    int            test_base = 0;
    logic [MW-1:0] last_result;
    integer        seed;

    modexp_top dut (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_data  (cmd_data),
        .result    (result),
        .done      (done),
        .busy      (busy),
        .reject    (reject),
        .op_count  (op_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Power by repeated multiplication
    function automatic logic [MW-1:0] ref_modexp(input logic [MW-1:0] m,
                                                 input logic [EW-1:0] e,
                                                 input logic [MW-1:0] b);
        logic [2*MW-1:0] r;
        int              i;
        r = 1 % m;
        for (i = 0; i < e; i++) begin
            r = (r * b) % m;
        end
        return r[MW-1:0];
    endfunction

    // Position of the highest set bit plus one
    function automatic int bit_length(input logic [EW-1:0] e);
        int n;
        int i;
        n = 0;
        for (i = 0; i < EW; i++) begin
            if (e[i]) begin
                n = i + 1;
            end
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        n_errors++;
        $display("Fail: time=%0t signal=%s expected=%0h actual=%0h", $time, name, expv, actv);
    endtask

    task automatic issue_cmd(input cmd_op_e op, input logic [MW-1:0] data);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_data  <= data;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= CMD_NOP;
        cmd_data  <= '0;
    endtask

    task automatic load_operands(input logic [MW-1:0] m, input logic [EW-1:0] e,
                                 input logic [MW-1:0] b);
        issue_cmd(CMD_LOAD_MOD, m);
        issue_cmd(CMD_LOAD_EXP, MW'(e));
        issue_cmd(CMD_LOAD_MSG, b);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((done_val_q.size() + rej_t0_q.size()) != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((done_val_q.size() + rej_t0_q.size()) != 0) begin
            n_errors++;
            $display("Timeout at %0t: %0d expected responses never arrived", $time,
                     done_val_q.size() + rej_t0_q.size());
            done_val_q.delete();
            done_t0_q.delete();
            done_lat_q.delete();
            rej_t0_q.delete();
        end
    endtask

    // Start on already loaded operands and wait for done
    task automatic start_op(input logic [MW-1:0] m, input logic [EW-1:0] e,
                            input logic [MW-1:0] b);
        issue_cmd(CMD_START, '0);
        done_val_q.push_back(ref_modexp(m, e, b));
        done_t0_q.push_back($time);
        done_lat_q.push_back(bit_length(e) + 3);
        bus_idle();
        wait_drain(MAX_LAT + 4);
    endtask

    task automatic run_op(input logic [MW-1:0] m, input logic [EW-1:0] e,
                          input logic [MW-1:0] b);
        load_operands(m, e, b);
        start_op(m, e, b);
    endtask

    task automatic start_rejected();
        issue_cmd(CMD_START, '0);
        rej_t0_q.push_back($time);
    endtask

    task automatic end_test(input string name);
        $display("test %-12s finished, %0d errors", name, n_errors - test_base);
        test_base = n_errors;
    endtask

    // Compare process, outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        logic [MW-1:0] expv;
        time           t0;
        int            lat;
        int            meas;
        if (!rst) begin
            if (done && reject) begin
                n_errors++;
                $display("done and reject were high together at %0t", $time);
            end
            if (done) begin
                if (done_val_q.size() == 0) begin
                    n_errors++;
                    $display("Unexpected done at %0t with no start pending", $time);
                end else begin
                    expv = done_val_q.pop_front();
                    t0 = done_t0_q.pop_front();
                    lat = done_lat_q.pop_front();
                    n_done = n_done + 1;
                    meas = int'(($time - t0 - CLK_PERIOD / 2) / CLK_PERIOD);
                    n_checks = n_checks + 3;
                    if (result !== expv) report_mismatch("result", expv, result);
                    if (meas != lat) report_mismatch("done_latency", lat, meas);
                    if (op_count !== CW'(n_done)) begin
                        report_mismatch("op_count", CW'(n_done), op_count);
                    end
                    last_result = expv;
                end
            end
            if (reject) begin
                if (rej_t0_q.size() == 0) begin
                    n_errors++;
                    $display("Unexpected reject at %0t on an acceptable start", $time);
                end else begin
                    t0 = rej_t0_q.pop_front();
                    meas = int'(($time - t0 - CLK_PERIOD / 2) / CLK_PERIOD);
                    n_checks = n_checks + 3;
                    if (meas != 1) report_mismatch("reject_latency", 1, meas);
                    if (result !== last_result) report_mismatch("result", last_result, result);
                    if (op_count !== CW'(n_done)) begin
                        report_mismatch("op_count", CW'(n_done), op_count);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [MW-1:0] m;
        logic [MW-1:0] b;
        logic [EW-1:0] e;
        int            i;
        clk = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = CMD_NOP;
        cmd_data = '0;
        seed = 32'haed;
        last_result = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs straight after reset
        @(negedge clk);
        n_checks = n_checks + 5;
        if (done !== 1'b0) report_mismatch("done", 0, done);
        if (busy !== 1'b0) report_mismatch("busy", 0, busy);
        if (reject !== 1'b0) report_mismatch("reject", 0, reject);
        if (result !== '0) report_mismatch("result", 0, result);
        if (op_count !== '0) report_mismatch("op_count", 0, op_count);
        end_test("reset_state");

        run_op(16'd1000, 4'd0, 16'd123);
        run_op(16'd1000, 4'd1, 16'd1234);
        run_op(16'd65521, 4'd15, 16'd12345);
        run_op(16'd97, 4'd5, 16'd0);
        run_op(16'd97, 4'd3, 16'd97);
        run_op(16'd2, 4'd7, 16'd3);
        run_op(16'hffff, 4'd15, 16'hfffe);
        run_op(16'd13, 4'd2, 16'd5);
        // NOP and an unlisted code leave the operands alone
        issue_cmd(CMD_NOP, 16'hffff);
        issue_cmd(cmd_op_e'(3'd7), 16'hffff);
        bus_idle();
        start_op(16'd13, 4'd2, 16'd5);
        end_test("directed");

        for (i = 0; i < 200; i++) begin
            m = $random(seed);
            e = $random(seed);
            b = $random(seed);
            if (m < 2) begin
                m = m + 2;
            end
            run_op(m, e, b);
        end
        end_test("random");

        // Moduli below 2 are refused
        load_operands(16'd0, 4'd3, 16'd5);
        start_rejected();
        bus_idle();
        wait_drain(MAX_LAT);
        repeat (8) @(negedge clk);
        load_operands(16'd1, 4'd15, 16'd7);
        start_rejected();
        bus_idle();
        wait_drain(MAX_LAT);
        repeat (8) @(negedge clk);
        end_test("bad_modulus");

        // Second start and new loads land while the first run is busy
        load_operands(16'd60013, 4'd15, 16'd4321);
        issue_cmd(CMD_START, '0);
        done_val_q.push_back(ref_modexp(16'd60013, 4'd15, 16'd4321));
        done_t0_q.push_back($time);
        done_lat_q.push_back(bit_length(4'd15) + 3);
        bus_idle();
        start_rejected();
        load_operands(16'd251, 4'd13, 16'd1000);
        bus_idle();
        wait_drain(MAX_LAT + 8);
        start_op(16'd251, 4'd13, 16'd1000);
        end_test("busy_start");

        if (dut.u_props.fail_count != 0) begin
            n_errors = n_errors + dut.u_props.fail_count;
            $display("Bound assertions failed %0d times", dut.u_props.fail_count);
        end

        $display("checks=%0d errors=%0d completions=%0d", n_checks, n_errors, n_done);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/modexp_pkg.sv
logic/modexp_cmd_decode.sv
logic/modexp_engine.sv
logic/modexp_result.sv
logic/modexp_top.sv
testbench/modexp_properties.sv
testbench/modexp_tb.sv

// File: Bender.yml
package:
  name: modexp

sources:
  - include_dirs:
      - logic
    files:
      - logic/modexp_pkg.sv
      - logic/modexp_cmd_decode.sv
      - logic/modexp_engine.sv
      - logic/modexp_result.sv
      - logic/modexp_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/modexp_properties.sv
      - testbench/modexp_tb.sv
